// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0 -Wno-fatal
TOP      = rename_tb
FILELIST = rename.f
BUILD    = obj_dir
SIM      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/rename_properties.sv
module rename_properties (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_fire,
  input  logic                         i_sc_valid,
  input  rename_types_pkg::slot_mask_t i_alloc,
  input  rename_types_pkg::slot_mask_t i_empty,
  input  rename_types_pkg::rnid_t      i_new_rnid [rename_cfg_pkg::DISP_SIZE]
);

  timeunit 1ns;
  timeprecision 1ps;

  import rename_cfg_pkg::*;

  // scheduler output is the fire delayed by one edge
  a_sc_valid_after_fire : assert property (
    @(posedge i_clk) disable iff (!i_reset_n) i_fire |=> i_sc_valid)
    else $error("scheduler valid missing one cycle after a fire");

  a_sc_valid_only_after_fire : assert property (
    @(posedge i_clk) disable iff (!i_reset_n) !i_fire |=> !i_sc_valid)
    else $error("scheduler valid without a fire in the previous cycle");

  generate
    for (genvar d = 0; d < DISP_SIZE; d++) begin : g_slot
      a_no_pop_when_empty : assert property (
        @(posedge i_clk) disable iff (!i_reset_n) !(i_alloc[d] && i_empty[d]))
        else $error("free list %0d popped while empty", d);

      a_dest_not_id0 : assert property (
        @(posedge i_clk) disable iff (!i_reset_n) i_alloc[d] |-> (i_new_rnid[d] != '0))
        else $error("slot %0d allocated physical id 0", d);
    end
  endgenerate

endmodule

bind rename_top rename_properties u_properties (
  .i_clk      (i_clk),
  .i_reset_n  (i_reset_n),
  .i_fire     (w_fire),
  .i_sc_valid (o_sc_valid),
  .i_alloc    (w_alloc),
  .i_empty    (w_empty),
  .i_new_rnid (w_new_rnid)
);

// File: bench/rename_tb.sv
module rename_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  localparam int TEST_N      = 6;
  localparam int TEST_CYCLES = 200;
  localparam int WAIT_LIMIT  = 50;  // cycles per handshake wait

  logic  i_clk;
  logic  i_reset_n;
  logic  i_disp_valid;
  logic  o_disp_ready;
  logic  i_rd_valid [DISP_SIZE];
  arch_t i_rd_arch [DISP_SIZE];
  arch_t i_rs1_arch [DISP_SIZE];
  arch_t i_rs2_arch [DISP_SIZE];
  logic  o_sc_valid;
  rnid_t o_sc_rd_rnid [DISP_SIZE];
  rnid_t o_sc_rd_old_rnid [DISP_SIZE];
  rnid_t o_sc_rs1_rnid [DISP_SIZE];
  logic  o_sc_rs1_ready [DISP_SIZE];
  rnid_t o_sc_rs2_rnid [DISP_SIZE];
  logic  o_sc_rs2_ready [DISP_SIZE];
  logic  i_wb_valid;
  rnid_t i_wb_rnid;
  logic  i_cmt_valid [DISP_SIZE];
  rnid_t i_cmt_old_rnid [DISP_SIZE];

  // reference model state
  rnid_t  model_map [ARCH_N];
  logic   model_ready [RNID_N];
  rnid_t  free_q [DISP_SIZE][$];
  rnid_t  last_old [DISP_SIZE];   // old ids of the latest group
  integer seed = 32'h4a5;
  int     errors = 0;
  int     checks = 0;
  int     err_mark = 0;

  rename_top u_dut (.*);

  always #4 i_clk = ~i_clk;

  task automatic check_rnid(input string name, input rnid_t exp, input rnid_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  function automatic arch_t rand_arch(input bit nonzero);
    int unsigned r;
    r = $random(seed);
    if (nonzero) return arch_t'(r % (ARCH_N - 1) + 1);
    return arch_t'(r % ARCH_N);
  endfunction

  // drive one group, predict it from the model, check the scheduler side
  task automatic send_group(input logic v0, input arch_t rd0, input arch_t a0, input arch_t b0,
                            input logic v1, input arch_t rd1, input arch_t a1, input arch_t b1,
                            input logic wbv = 1'b0, input rnid_t wbid = '0);
    logic  rdv [DISP_SIZE];
    arch_t rd [DISP_SIZE];
    arch_t rs1 [DISP_SIZE];
    arch_t rs2 [DISP_SIZE];
    logic  need [DISP_SIZE];
    rnid_t new_id [DISP_SIZE];
    rnid_t exp_old [DISP_SIZE];
    rnid_t exp_rs1 [DISP_SIZE];
    rnid_t exp_rs2 [DISP_SIZE];
    logic  exp_rdy1 [DISP_SIZE];
    logic  exp_rdy2 [DISP_SIZE];
    int    n;
    rdv = '{v0, v1};
    rd  = '{rd0, rd1};
    rs1 = '{a0, a1};
    rs2 = '{b0, b1};
    @(posedge i_clk);
    i_disp_valid <= 1'b1;
    i_wb_valid   <= wbv;
    i_wb_rnid    <= wbid;
    for (int d = 0; d < DISP_SIZE; d++) begin
      i_rd_valid[d]  <= rdv[d];
      i_rd_arch[d]   <= rd[d];
      i_rs1_arch[d]  <= rs1[d];
      i_rs2_arch[d]  <= rs2[d];
      i_cmt_valid[d] <= 1'b0;  // ends any commit pulse
    end
    n = 0;
    do begin
      @(negedge i_clk);
      n++;
    end while (!o_disp_ready && n < WAIT_LIMIT);
    if (!o_disp_ready) begin
      errors++;
      $display("dispatch stalled for %0d cycles, group was never accepted", n);
      @(posedge i_clk);
      i_disp_valid <= 1'b0;
      i_wb_valid   <= 1'b0;
      return;
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      need[d]   = rdv[d] && (rd[d] != '0);
      new_id[d] = '0;
      if (need[d] && free_q[d].size() == 0) begin
        errors++;
        $display("slot %0d accepted a destination while its free list is empty", d);
      end else if (need[d]) begin
        new_id[d] = free_q[d].pop_front();
      end
      exp_rs1[d]  = model_map[rs1[d]];
      exp_rs2[d]  = model_map[rs2[d]];
      exp_old[d]  = model_map[rd[d]];
      exp_rdy1[d] = model_ready[exp_rs1[d]] || (wbv && wbid == exp_rs1[d]);
      exp_rdy2[d] = model_ready[exp_rs2[d]] || (wbv && wbid == exp_rs2[d]);
    end
    // slot 1 sees slot 0's fresh destination
    if (need[0] && rd[0] == rs1[1]) begin
      exp_rs1[1]  = new_id[0];
      exp_rdy1[1] = 1'b0;
    end
    if (need[0] && rd[0] == rs2[1]) begin
      exp_rs2[1]  = new_id[0];
      exp_rdy2[1] = 1'b0;
    end
    if (need[0] && rdv[1] && rd[0] == rd[1]) exp_old[1] = new_id[0];
    if (wbv) model_ready[wbid] = 1'b1;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (need[d]) begin
        model_map[rd[d]]      = new_id[d];  // slot 1 written last
        model_ready[new_id[d]] = 1'b0;
      end
    end
    @(posedge i_clk);  // fire edge
    i_disp_valid <= 1'b0;
    i_wb_valid   <= 1'b0;
    n = 0;
    do begin
      @(negedge i_clk);
      n++;
    end while (!o_sc_valid && n < WAIT_LIMIT);
    if (!o_sc_valid) begin
      errors++;
      $display("no scheduler output after an accepted group");
      return;
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      check_rnid($sformatf("o_sc_rd_rnid[%0d]", d), new_id[d], o_sc_rd_rnid[d]);
      if (rdv[d]) check_rnid($sformatf("o_sc_rd_old_rnid[%0d]", d), exp_old[d], o_sc_rd_old_rnid[d]);
      check_rnid($sformatf("o_sc_rs1_rnid[%0d]", d), exp_rs1[d], o_sc_rs1_rnid[d]);
      check_rnid($sformatf("o_sc_rs2_rnid[%0d]", d), exp_rs2[d], o_sc_rs2_rnid[d]);
      check_bit($sformatf("o_sc_rs1_ready[%0d]", d), exp_rdy1[d], o_sc_rs1_ready[d]);
      check_bit($sformatf("o_sc_rs2_ready[%0d]", d), exp_rdy2[d], o_sc_rs2_ready[d]);
      last_old[d] = exp_old[d];
    end
  endtask

  // slot 0 group held valid while its free list is empty
  task automatic expect_stall(input arch_t rd0);
    @(posedge i_clk);
    i_disp_valid  <= 1'b1;
    i_rd_valid[0] <= 1'b1;
    i_rd_arch[0]  <= rd0;
    i_rd_valid[1] <= 1'b0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      i_rs1_arch[d] <= '0;
      i_rs2_arch[d] <= '0;
    end
    repeat (3) begin
      @(negedge i_clk);
      check_bit("o_disp_ready", 1'b0, o_disp_ready);
    end
  endtask

  // pulse is closed by the next send_group
  task automatic return_id(input int slot, input rnid_t id);
    @(posedge i_clk);
    i_cmt_valid[slot]    <= 1'b1;
    i_cmt_old_rnid[slot] <= id;
    free_q[slot].push_back(id);
  endtask

  task automatic test_done(input string name);
    $display("test %-18s finished, %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic test_reset_map();
    repeat (3) begin
      send_group(0, 0, rand_arch(0), rand_arch(0), 0, 0, rand_arch(0), rand_arch(0));
    end
  endtask

  task automatic test_alloc_order();
    repeat (4) begin
      send_group(1, rand_arch(1), rand_arch(0), rand_arch(0),
                 1, rand_arch(1), rand_arch(0), rand_arch(0));
    end
  endtask

  task automatic test_forwarding();
    send_group(1, 5'd7, 5'd1, 5'd2, 1, 5'd7, 5'd7, 5'd7);
    send_group(0, 5'd0, 5'd7, 5'd7, 0, 5'd0, 5'd7, 5'd0);  // sees slot 1's id
  endtask

  task automatic test_writeback();
    rnid_t id;
    send_group(1, 5'd9, 5'd0, 5'd0, 0, 5'd0, 5'd0, 5'd0);
    id = model_map[9];
    send_group(0, 5'd0, 5'd9, 5'd9, 0, 5'd0, 5'd9, 5'd0);
    check_bit("o_sc_rs1_ready[0]", 1'b0, o_sc_rs1_ready[0]);
    send_group(0, 5'd0, 5'd9, 5'd9, 0, 5'd0, 5'd9, 5'd0, 1'b1, id);  // same-cycle wb
    check_bit("o_sc_rs1_ready[0]", 1'b1, o_sc_rs1_ready[0]);
    send_group(0, 5'd0, 5'd9, 5'd0, 0, 5'd0, 5'd0, 5'd9);
    check_bit("o_sc_rs2_ready[1]", 1'b1, o_sc_rs2_ready[1]);
  endtask

  task automatic test_exhaust_commit();
    rnid_t ret;
    while (free_q[0].size() > 0) begin
      send_group(1, rand_arch(1), rand_arch(0), rand_arch(0), 0, 5'd0, 5'd0, 5'd0);
    end
    ret = last_old[0];
    expect_stall(5'd3);
    return_id(0, ret);
    send_group(1, 5'd3, 5'd0, 5'd0, 0, 5'd0, 5'd0, 5'd0);
    check_rnid("o_sc_rd_rnid[0]", ret, o_sc_rd_rnid[0]);  // only entry left
  endtask

  task automatic test_x0();
    send_group(1, 5'd0, 5'd0, 5'd0, 1, 5'd0, 5'd0, 5'd4);
    check_rnid("o_sc_rd_rnid[0]", '0, o_sc_rd_rnid[0]);
    check_rnid("o_sc_rd_rnid[1]", '0, o_sc_rd_rnid[1]);
    check_bit("o_sc_rs1_ready[1]", 1'b1, o_sc_rs1_ready[1]);
    send_group(0, 5'd0, 5'd0, 5'd0, 1, rand_arch(1), 5'd0, 5'd0);  // sequence unchanged
  endtask

  initial begin
    i_clk        = 1'b0;
    i_reset_n    = 1'b0;
    i_disp_valid = 1'b0;
    i_wb_valid   = 1'b0;
    i_wb_rnid    = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      i_rd_valid[d]     = 1'b0;
      i_rd_arch[d]      = '0;
      i_rs1_arch[d]     = '0;
      i_rs2_arch[d]     = '0;
      i_cmt_valid[d]    = 1'b0;
      i_cmt_old_rnid[d] = '0;
      for (int i = 0; i < FLIST_SIZE; i++) begin
        free_q[d].push_back(rnid_t'(FLIST_BASE + FLIST_SIZE * d + i));
      end
    end
    for (int a = 0; a < ARCH_N; a++) model_map[a] = rnid_t'(a);
    for (int r = 0; r < RNID_N; r++) model_ready[r] = 1'b1;
    repeat (5) @(posedge i_clk);
    i_reset_n <= 1'b1;
    test_reset_map();
    test_done("reset_map");
    test_alloc_order();
    test_done("alloc_order");
    test_forwarding();
    test_done("forwarding");
    test_writeback();
    test_done("writeback");
    test_exhaust_commit();
    test_done("exhaust_commit");
    test_x0();
    test_done("x0");
    $display("%0d tests, %0d checks, %0d errors", TEST_N, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TEST_N * TEST_CYCLES * 8);
    $display("watchdog expired at %0t ns, the tests did not finish", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: rename.f
verilog/rename_cfg_pkg.sv
verilog/rename_types_pkg.sv
verilog/rename_freelist.sv
verilog/rename_map.sv
verilog/rename_bypass.sv
verilog/rename_ready_table.sv
verilog/rename_top.sv
bench/rename_properties.sv
bench/rename_tb.sv

// File: verilog/rename_bypass.sv
module rename_bypass (
  // group fields
  input  rename_types_pkg::slot_mask_t i_rd_valid,
  input  rename_types_pkg::arch_t    i_rd_arch         [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::arch_t    i_rs1_arch        [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::arch_t    i_rs2_arch        [rename_cfg_pkg::DISP_SIZE],

  // freshly allocated ids
  input  rename_types_pkg::rnid_t    i_new_rnid        [rename_cfg_pkg::DISP_SIZE],

  // map table results
  input  rename_types_pkg::rnid_t    i_map_rs1_rnid    [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::rnid_t    i_map_rs2_rnid    [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::rnid_t    i_map_rd_old_rnid [rename_cfg_pkg::DISP_SIZE],

  output rename_types_pkg::rnid_t    o_rs1_rnid        [rename_cfg_pkg::DISP_SIZE],
  output rename_types_pkg::rnid_t    o_rs2_rnid        [rename_cfg_pkg::DISP_SIZE],
  output rename_types_pkg::rnid_t    o_rd_old_rnid     [rename_cfg_pkg::DISP_SIZE],
  output logic                       o_rs1_fwd         [rename_cfg_pkg::DISP_SIZE],
  output logic                       o_rs2_fwd         [rename_cfg_pkg::DISP_SIZE]
);

  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  always_comb begin
    slot_mask_t w_wr;  // slot writes a real register

    for (int p = 0; p < DISP_SIZE; p++) begin
      w_wr[p] = i_rd_valid[p] & (i_rd_arch[p] != '0);  // x0 never matches
    end

    for (int d = 0; d < DISP_SIZE; d++) begin
      o_rs1_rnid[d]    = i_map_rs1_rnid[d];
      o_rs2_rnid[d]    = i_map_rs2_rnid[d];
      o_rd_old_rnid[d] = i_map_rd_old_rnid[d];
      o_rs1_fwd[d]     = 1'b0;
      o_rs2_fwd[d]     = 1'b0;
      // older slots only; the youngest match wins
      for (int p = 0; p < d; p++) begin
        if (w_wr[p] && (i_rd_arch[p] == i_rs1_arch[d])) begin
          o_rs1_rnid[d] = i_new_rnid[p];
          o_rs1_fwd[d]  = 1'b1;
        end
        if (w_wr[p] && (i_rd_arch[p] == i_rs2_arch[d])) begin
          o_rs2_rnid[d] = i_new_rnid[p];
          o_rs2_fwd[d]  = 1'b1;
        end
        if (w_wr[p] && i_rd_valid[d] && (i_rd_arch[p] == i_rd_arch[d])) begin
          o_rd_old_rnid[d] = i_new_rnid[p];  // waw inside the group
        end
      end
    end
  end

endmodule

// File: verilog/rename_cfg_pkg.sv
package rename_cfg_pkg;

  // dispatch group
  localparam int DISP_SIZE  = 2;                   // slots per group

  // architectural register file
  localparam int ARCH_N     = 32;
  localparam int ARCH_W     = $clog2(ARCH_N);      // 5

  // physical register file
  localparam int RNID_N     = 64;
  localparam int RNID_W     = $clog2(RNID_N);      // 6

  // per-slot free lists
  localparam int FLIST_SIZE = 16;
  localparam int FLIST_W    = $clog2(FLIST_SIZE);  // 4

  // slot d's list starts at FLIST_BASE + FLIST_SIZE*d
  localparam int FLIST_BASE = 32;

endpackage

// File: verilog/rename_freelist.sv
module rename_freelist #(
  parameter int INIT_BASE = 32
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  input  logic                    i_push,
  input  rename_types_pkg::rnid_t i_push_id,

  input  logic                    i_pop,
  output rename_types_pkg::rnid_t o_pop_id,
  output logic                    o_empty
);

  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  rnid_t              r_list [FLIST_SIZE];
  logic [FLIST_W-1:0] r_head;
  logic [FLIST_W-1:0] r_tail;
  logic [FLIST_W:0]   r_count;  // one extra bit to tell full from empty

  // list contents, preloaded with consecutive ids
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < FLIST_SIZE; i++) begin
        r_list[i] <= rnid_t'(INIT_BASE + i);
      end
    end else if (i_push) begin
      r_list[r_tail] <= i_push_id;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;               // full list, tail wraps onto head
      r_count <= FLIST_SIZE[FLIST_W:0];
    end else begin
      if (i_pop)  r_head <= r_head + 1'b1;
      if (i_push) r_tail <= r_tail + 1'b1;
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: ;                 // both or neither, count holds
      endcase
    end
  end

  assign o_pop_id = r_list[r_head];  // head is visible before the pop
  assign o_empty  = (r_count == '0);

endmodule

// File: verilog/rename_map.sv
module rename_map (
  input  logic                       i_clk,
  input  logic                       i_reset_n,

  // lookups, per slot
  input  rename_types_pkg::arch_t    i_rs1_arch    [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::arch_t    i_rs2_arch    [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::arch_t    i_rd_arch     [rename_cfg_pkg::DISP_SIZE],
  output rename_types_pkg::rnid_t    o_rs1_rnid    [rename_cfg_pkg::DISP_SIZE],
  output rename_types_pkg::rnid_t    o_rs2_rnid    [rename_cfg_pkg::DISP_SIZE],
  output rename_types_pkg::rnid_t    o_rd_old_rnid [rename_cfg_pkg::DISP_SIZE],

  // group update at the fire edge
  input  rename_types_pkg::slot_mask_t i_update,
  input  rename_types_pkg::rnid_t    i_update_rnid [rename_cfg_pkg::DISP_SIZE]
);

  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  rnid_t r_map [ARCH_N];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      // identity mapping, x0 -> id 0
      for (int a = 0; a < ARCH_N; a++) begin
        r_map[a] <= rnid_t'(a);
      end
    end else begin
      // ascending slot order, so slot 1 wins on the same rd
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_update[d] && (i_rd_arch[d] != '0)) begin
          r_map[i_rd_arch[d]] <= i_update_rnid[d];
        end
      end
    end
  end

  generate
    for (genvar d = 0; d < DISP_SIZE; d++) begin : g_read
      assign o_rs1_rnid[d]    = r_map[i_rs1_arch[d]];
      assign o_rs2_rnid[d]    = r_map[i_rs2_arch[d]];
      assign o_rd_old_rnid[d] = r_map[i_rd_arch[d]];  // the id being replaced
    end
  endgenerate

endmodule

// File: verilog/rename_ready_table.sv
module rename_ready_table (
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  // new destinations, cleared at the fire edge
  input  rename_types_pkg::slot_mask_t i_alloc,
  input  rename_types_pkg::rnid_t      i_alloc_rnid [rename_cfg_pkg::DISP_SIZE],

  input  logic                         i_wb_valid,
  input  rename_types_pkg::rnid_t      i_wb_rnid,

  input  rename_types_pkg::rnid_t      i_rs1_rnid   [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::rnid_t      i_rs2_rnid   [rename_cfg_pkg::DISP_SIZE],
  output logic                         o_rs1_ready  [rename_cfg_pkg::DISP_SIZE],
  output logic                         o_rs2_ready  [rename_cfg_pkg::DISP_SIZE]
);

  import rename_cfg_pkg::*;

  logic [RNID_N-1:0] r_ready;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ready <= '1;
    end else begin
      if (i_wb_valid) r_ready[i_wb_rnid] <= 1'b1;
      // allocation comes last so it beats a writeback of the same id
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_alloc[d] && (i_alloc_rnid[d] != '0)) begin
          r_ready[i_alloc_rnid[d]] <= 1'b0;
        end
      end
    end
  end

  // same-cycle writeback counts as ready
  generate
    for (genvar d = 0; d < DISP_SIZE; d++) begin : g_lookup
      assign o_rs1_ready[d] = r_ready[i_rs1_rnid[d]] | (i_wb_valid & (i_wb_rnid == i_rs1_rnid[d]));
      assign o_rs2_ready[d] = r_ready[i_rs2_rnid[d]] | (i_wb_valid & (i_wb_rnid == i_rs2_rnid[d]));
    end
  endgenerate

endmodule

// File: verilog/rename_top.sv
module rename_top (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // dispatch in
  input  logic                    i_disp_valid,
  output logic                    o_disp_ready,
  input  logic                    i_rd_valid       [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::arch_t i_rd_arch        [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::arch_t i_rs1_arch       [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::arch_t i_rs2_arch       [rename_cfg_pkg::DISP_SIZE],

  // dispatch out, no back-pressure
  output logic                    o_sc_valid,
  output rename_types_pkg::rnid_t o_sc_rd_rnid     [rename_cfg_pkg::DISP_SIZE],
  output rename_types_pkg::rnid_t o_sc_rd_old_rnid [rename_cfg_pkg::DISP_SIZE],
  output rename_types_pkg::rnid_t o_sc_rs1_rnid    [rename_cfg_pkg::DISP_SIZE],
  output logic                    o_sc_rs1_ready   [rename_cfg_pkg::DISP_SIZE],
  output rename_types_pkg::rnid_t o_sc_rs2_rnid    [rename_cfg_pkg::DISP_SIZE],
  output logic                    o_sc_rs2_ready   [rename_cfg_pkg::DISP_SIZE],

  input  logic                    i_wb_valid,
  input  rename_types_pkg::rnid_t i_wb_rnid,

  input  logic                    i_cmt_valid      [rename_cfg_pkg::DISP_SIZE],
  input  rename_types_pkg::rnid_t i_cmt_old_rnid   [rename_cfg_pkg::DISP_SIZE]
);

  import rename_cfg_pkg::*;
  import rename_types_pkg::*;

  logic       w_fire;
  slot_mask_t w_rd_valid;
  slot_mask_t w_need;   // slot wants a fresh id
  slot_mask_t w_empty;
  slot_mask_t w_alloc;
  rnid_t      w_pop_id [DISP_SIZE];
  rnid_t      w_new_rnid [DISP_SIZE];
  rnid_t      w_map_rs1_rnid [DISP_SIZE];
  rnid_t      w_map_rs2_rnid [DISP_SIZE];
  rnid_t      w_map_rd_old_rnid [DISP_SIZE];
  rnid_t      w_rs1_rnid [DISP_SIZE];
  rnid_t      w_rs2_rnid [DISP_SIZE];
  rnid_t      w_rd_old_rnid [DISP_SIZE];
  logic       w_rs1_fwd [DISP_SIZE];
  logic       w_rs2_fwd [DISP_SIZE];
  logic       w_rs1_ready [DISP_SIZE];
  logic       w_rs2_ready [DISP_SIZE];

  generate
    for (genvar d = 0; d < DISP_SIZE; d++) begin : g_slot
      assign w_rd_valid[d] = i_rd_valid[d];
      assign w_need[d]     = i_rd_valid[d] & (i_rd_arch[d] != '0);
      assign w_alloc[d]    = w_fire & w_need[d];

      rename_freelist #(
        .INIT_BASE (FLIST_BASE + FLIST_SIZE * d)
      ) u_freelist (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (i_cmt_valid[d]),
        .i_push_id (i_cmt_old_rnid[d]),
        .i_pop     (w_alloc[d]),
        .o_pop_id  (w_pop_id[d]),
        .o_empty   (w_empty[d])
      );

      assign w_new_rnid[d] = w_need[d] ? w_pop_id[d] : '0;  // x0 stays on id 0
    end
  endgenerate

  // stall only when a slot needs an id its list can't give
  assign o_disp_ready = ~|(w_need & w_empty);
  assign w_fire       = i_disp_valid & o_disp_ready;

  rename_map u_map (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rs1_arch    (i_rs1_arch),
    .i_rs2_arch    (i_rs2_arch),
    .i_rd_arch     (i_rd_arch),
    .o_rs1_rnid    (w_map_rs1_rnid),
    .o_rs2_rnid    (w_map_rs2_rnid),
    .o_rd_old_rnid (w_map_rd_old_rnid),
    .i_update      (w_alloc),
    .i_update_rnid (w_new_rnid)
  );

  rename_bypass u_bypass (
    .i_rd_valid        (w_rd_valid),
    .i_rd_arch         (i_rd_arch),
    .i_rs1_arch        (i_rs1_arch),
    .i_rs2_arch        (i_rs2_arch),
    .i_new_rnid        (w_new_rnid),
    .i_map_rs1_rnid    (w_map_rs1_rnid),
    .i_map_rs2_rnid    (w_map_rs2_rnid),
    .i_map_rd_old_rnid (w_map_rd_old_rnid),
    .o_rs1_rnid        (w_rs1_rnid),
    .o_rs2_rnid        (w_rs2_rnid),
    .o_rd_old_rnid     (w_rd_old_rnid),
    .o_rs1_fwd         (w_rs1_fwd),
    .o_rs2_fwd         (w_rs2_fwd)
  );

  rename_ready_table u_ready (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_alloc      (w_alloc),
    .i_alloc_rnid (w_new_rnid),
    .i_wb_valid   (i_wb_valid),
    .i_wb_rnid    (i_wb_rnid),
    .i_rs1_rnid   (w_rs1_rnid),
    .i_rs2_rnid   (w_rs2_rnid),
    .o_rs1_ready  (w_rs1_ready),
    .o_rs2_ready  (w_rs2_ready)
  );

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_sc_valid <= 1'b0;
    end else begin
      o_sc_valid <= w_fire;  // one cycle after the fire edge
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fire) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        o_sc_rd_rnid[d]     <= w_new_rnid[d];
        o_sc_rd_old_rnid[d] <= w_rd_old_rnid[d];
        o_sc_rs1_rnid[d]    <= w_rs1_rnid[d];
        o_sc_rs2_rnid[d]    <= w_rs2_rnid[d];
        // a value produced inside this group can't be ready yet
        o_sc_rs1_ready[d]   <= w_rs1_ready[d] & ~w_rs1_fwd[d];
        o_sc_rs2_ready[d]   <= w_rs2_ready[d] & ~w_rs2_fwd[d];
      end
    end
  end

endmodule

// File: verilog/rename_types_pkg.sv
package rename_types_pkg;

  // architectural register index
  typedef logic [rename_cfg_pkg::ARCH_W-1:0] arch_t;

  // physical register id, 0 is the hardwired x0
  typedef logic [rename_cfg_pkg::RNID_W-1:0] rnid_t;

  // one bit per dispatch slot
  typedef logic [rename_cfg_pkg::DISP_SIZE-1:0] slot_mask_t;

endpackage
